// ==== Bender.yml ====
package:
  name: miner_afu

sources:
  - design/miner_pkg.sv
  - design/mmio_regs.sv
  - design/nonce_search.sv
  - design/miner_ctrl.sv
  - design/miner_afu.sv
  - target: test
    files:
      - testbench/miner_afu_checker.sv
      - testbench/miner_afu_tb.sv

// ==== design/miner_afu.sv ====
// miner accelerator top with the MMIO register map, job sequencer and search core
`timescale 1ns/100ps

module miner_afu (
   input  logic                                  clk,
   input  logic                                  rst,
   // MMIO
   input  logic                                  mmio_wr_en,
   input  logic [miner_pkg::MMIO_ADDR_WIDTH-1:0] mmio_wr_addr,
   input  logic [63:0]                           mmio_wr_data,
   input  logic                                  mmio_rd_en,
   input  logic [miner_pkg::MMIO_ADDR_WIDTH-1:0] mmio_rd_addr,
   output logic [63:0]                           mmio_rd_data,
   output logic                                  mmio_rd_valid,
   // DMA read channel
   output logic [miner_pkg::ADDR_WIDTH-1:0]      rd_addr,
   output logic [miner_pkg::SIZE_WIDTH-1:0]      rd_size,
   output logic                                  rd_go,
   output logic                                  rd_en,
   input  miner_pkg::line_t                      rd_data,
   input  logic                                  empty,
   // completion level of the read channel, observed by the bound checker only
   input  logic                                  rd_done,
   // DMA write channel
   output logic [miner_pkg::ADDR_WIDTH-1:0]      wr_addr,
   output logic [miner_pkg::SIZE_WIDTH-1:0]      wr_size,
   output logic                                  wr_go,
   output logic                                  wr_en,
   output miner_pkg::line_t                      wr_data,
   input  logic                                  full,
   input  logic                                  wr_done
);
   import miner_pkg::*;

   // programmed job parameters from the register map
   logic                  go;
   logic [ADDR_WIDTH-1:0] rd_base;
   logic [ADDR_WIDTH-1:0] wr_base;
   logic [SIZE_WIDTH-1:0] size;

   // sequencer to search core
   logic        search_start;
   logic [31:0] search_seed;
   logic [31:0] search_target;
   logic        search_done;
   logic        found;
   logic [30:0] nonce;
   logic [31:0] hash;

   // ========================================
   // instances
   // ========================================

   // done is raised from the write channel completion inside the register map
   mmio_regs u_mmio_regs (.*);

   miner_ctrl u_miner_ctrl (.*);

   nonce_search u_nonce_search (.*);

endmodule

// ==== design/miner_ctrl.sv ====
// job sequencer that drives both DMA channels and feeds headers to the search core
`timescale 1ns/100ps

module miner_ctrl (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             go,
   input  logic [miner_pkg::ADDR_WIDTH-1:0] rd_base,
   input  logic [miner_pkg::ADDR_WIDTH-1:0] wr_base,
   input  logic [miner_pkg::SIZE_WIDTH-1:0] size,
   input  logic                             empty,
   input  miner_pkg::line_t                 rd_data,
   input  logic                             full,
   input  logic                             search_done,
   input  logic                             found,
   input  logic [30:0]                      nonce,
   input  logic [31:0]                      hash,
   output logic [miner_pkg::ADDR_WIDTH-1:0] rd_addr,
   output logic [miner_pkg::ADDR_WIDTH-1:0] wr_addr,
   output logic [miner_pkg::SIZE_WIDTH-1:0] rd_size,
   output logic [miner_pkg::SIZE_WIDTH-1:0] wr_size,
   output logic                             rd_go,
   output logic                             wr_go,
   output logic                             rd_en,
   output logic                             wr_en,
   output miner_pkg::line_t                 wr_data,
   output logic                             search_start,
   output logic [31:0]                      search_seed,
   output logic [31:0]                      search_target
);
   import miner_pkg::*;

   // headers still to be popped from the read channel
   logic [SIZE_WIDTH-1:0] pop_left;
   // one prefetched header waiting for the search core
   logic  hold_valid;
   line_t hold_line;
   logic  searching;
   // a packed result waiting for room in the write channel
   logic  res_valid;

   // ========================================
   // handshake decode
   // ========================================

   // start only when the core is idle and the result slot is free, since the core cannot stall
   assign search_start = hold_valid && !searching && !res_valid;
   assign search_seed = hold_line.hdr.seed;
   assign search_target = hold_line.hdr.target;

   // pop into the holding register when it is free or being handed to the core this cycle
   // no pop while rd_go is out, as the channel is only just starting
   assign rd_en = !empty && !rd_go && (pop_left != '0) && (!hold_valid || search_start);

   // a result goes out on the first cycle with room in the write channel
   assign wr_en = res_valid && !full;

   // ========================================
   // control state
   // ========================================

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_go <= 1'b0;
         wr_go <= 1'b0;
         pop_left <= '0;
         hold_valid <= 1'b0;
         searching <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         // both channels start one cycle after go
         rd_go <= go;
         wr_go <= go;
         if (go)
            pop_left <= size;
         else if (rd_en)
            pop_left <= pop_left - 1'b1;
         if (rd_en)
            hold_valid <= 1'b1;
         else if (search_start)
            hold_valid <= 1'b0;
         if (search_start)
            searching <= 1'b1;
         else if (search_done)
            searching <= 1'b0;
         if (search_done)
            res_valid <= 1'b1;
         else if (wr_en)
            res_valid <= 1'b0;
      end
   end

   // ========================================
   // payload registers
   // ========================================

   always_ff @(posedge clk) begin
      if (go) begin
         rd_addr <= rd_base;
         wr_addr <= wr_base;
         rd_size <= size;
         wr_size <= size;
      end
      if (rd_en)
         hold_line <= rd_data;
      // search outcome packed through the result view of the line
      if (search_done) begin
         wr_data.res.found <= found;
         wr_data.res.nonce <= nonce;
         wr_data.res.hash <= hash;
      end
   end

endmodule

// ==== design/miner_pkg.sv ====
// shared widths, MMIO register map, DMA line layout and hash rule for the miner accelerator

package miner_pkg;

   // ========================================
   // widths
   // ========================================

   // one DMA line, scaled down from a full 512-bit cache line
   localparam int LINE_WIDTH = 64;
   localparam int ADDR_WIDTH = 64;
   // job count and DMA transfer size in lines
   localparam int SIZE_WIDTH = 16;
   localparam int MMIO_ADDR_WIDTH = 4;

   // the search gives up after this nonce has been tried
   localparam int NONCE_LIMIT = 4095;

   // ========================================
   // MMIO register indices
   // ========================================

   localparam logic [MMIO_ADDR_WIDTH-1:0] REG_GO = 4'd0;
   localparam logic [MMIO_ADDR_WIDTH-1:0] REG_RD_BASE = 4'd1;
   localparam logic [MMIO_ADDR_WIDTH-1:0] REG_WR_BASE = 4'd2;
   localparam logic [MMIO_ADDR_WIDTH-1:0] REG_SIZE = 4'd3;
   localparam logic [MMIO_ADDR_WIDTH-1:0] REG_DONE = 4'd4;

   // a line read from the host is a job header, a line written back is a result
   typedef union packed {
      struct packed {
         logic [31:0] target;
         logic [31:0] seed;
      } hdr;
      struct packed {
         logic        found;
         logic [30:0] nonce;
         logic [31:0] hash;
      } res;
   } line_t;

   // integer mixing hash standing in for a real cryptographic hash
   function automatic logic [31:0] mix_hash(input logic [31:0] seed, input logic [30:0] nonce);
      logic [31:0] x;
      x = seed ^ {1'b0, nonce};
      x = x ^ (x >> 16);
      // product is truncated to the low 32 bits by the assignment width
      x = x * 32'h045D9F3B;
      x = x ^ (x >> 16);
      return x;
   endfunction

endpackage

// ==== design/mmio_regs.sv ====
// MMIO register file with base addresses, job count, go pulse and sticky done bit
`timescale 1ns/100ps

module mmio_regs (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                mmio_wr_en,
   input  logic [miner_pkg::MMIO_ADDR_WIDTH-1:0] mmio_wr_addr,
   input  logic [63:0]                         mmio_wr_data,
   input  logic                                mmio_rd_en,
   input  logic [miner_pkg::MMIO_ADDR_WIDTH-1:0] mmio_rd_addr,
   input  logic                                wr_done,
   output logic [63:0]                         mmio_rd_data,
   output logic                                mmio_rd_valid,
   output logic                                go,
   output logic [miner_pkg::ADDR_WIDTH-1:0]    rd_base,
   output logic [miner_pkg::ADDR_WIDTH-1:0]    wr_base,
   output logic [miner_pkg::SIZE_WIDTH-1:0]    size
);
   import miner_pkg::*;

   logic done;
   // previous wr_done level, used to find its rising edge
   logic wr_done_q;

   // ========================================
   // register writes, go and done
   // ========================================

   always_ff @(posedge clk) begin
      if (rst) begin
         go <= 1'b0;
         done <= 1'b0;
         wr_done_q <= 1'b0;
         rd_base <= '0;
         wr_base <= '0;
         size <= '0;
      end else begin
         wr_done_q <= wr_done;
         // a write to the go register turns into a single pulse one cycle later
         go <= mmio_wr_en && (mmio_wr_addr == REG_GO);
         if (mmio_wr_en) begin
            case (mmio_wr_addr)
               REG_RD_BASE: rd_base <= mmio_wr_data[ADDR_WIDTH-1:0];
               REG_WR_BASE: wr_base <= mmio_wr_data[ADDR_WIDTH-1:0];
               REG_SIZE:    size <= mmio_wr_data[SIZE_WIDTH-1:0];
               default:     ;
            endcase
         end
         // a new job clears done; otherwise done sets once the write channel finishes
         if (go)
            done <= 1'b0;
         else if (wr_done && !wr_done_q)
            done <= 1'b1;
      end
   end

   // ========================================
   // register reads, fixed one-cycle response
   // ========================================

   always_ff @(posedge clk) begin
      if (rst)
         mmio_rd_valid <= 1'b0;
      else
         mmio_rd_valid <= mmio_rd_en;
   end

   // the go register is write-only and reads back as zero
   always_ff @(posedge clk) begin
      case (mmio_rd_addr)
         REG_RD_BASE: mmio_rd_data <= 64'(rd_base);
         REG_WR_BASE: mmio_rd_data <= 64'(wr_base);
         REG_SIZE:    mmio_rd_data <= 64'(size);
         REG_DONE:    mmio_rd_data <= 64'(done);
         default:     mmio_rd_data <= '0;
      endcase
   end

endmodule

// ==== design/nonce_search.sv ====
// iterative nonce search that hashes one candidate per cycle against a target
`timescale 1ns/100ps

module nonce_search (
   input  logic        clk,
   input  logic        rst,
   input  logic        search_start,
   input  logic [31:0] search_seed,
   input  logic [31:0] search_target,
   output logic        search_done,
   output logic        found,
   output logic [30:0] nonce,
   output logic [31:0] hash
);
   import miner_pkg::*;

   logic        busy;
   logic [30:0] nonce_q;
   logic [31:0] seed_q;
   logic [31:0] target_q;
   logic [31:0] cur_hash;
   logic        hit;
   logic        last;

   // hash of the candidate held this cycle
   assign cur_hash = mix_hash(seed_q, nonce_q);
   assign hit = cur_hash < target_q;
   assign last = nonce_q == 31'(NONCE_LIMIT);

   // the search ends on the first hit or after the last allowed nonce
   // done is decoded from the running state so nonce n finishes n+1 cycles after start
   assign search_done = busy && (hit || last);
   assign found = hit;
   assign nonce = nonce_q;
   assign hash = cur_hash;

   // ========================================
   // search state
   // ========================================

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         nonce_q <= '0;
      end else if (search_start) begin
         busy <= 1'b1;
         nonce_q <= '0;
      end else if (busy) begin
         if (search_done)
            busy <= 1'b0;
         else
            nonce_q <= nonce_q + 31'd1;
      end
   end

   // seed and target stay fixed for the whole search
   always_ff @(posedge clk) begin
      if (search_start) begin
         seed_q <= search_seed;
         target_q <= search_target;
      end
   end

endmodule

// ==== list.f ====
design/miner_pkg.sv
design/mmio_regs.sv
design/nonce_search.sv
design/miner_ctrl.sv
design/miner_afu.sv
testbench/miner_afu_checker.sv
testbench/miner_afu_tb.sv

// ==== testbench/miner_afu_checker.sv ====
// bound protocol checker for the DMA channel strobes and the MMIO read latency
`timescale 1ns/100ps

module miner_afu_checker (
   input logic clk,
   input logic rst,
   input logic rd_en,
   input logic empty,
   input logic rd_done,
   input logic wr_en,
   input logic full,
   input logic rd_go,
   input logic wr_go,
   input logic mmio_rd_en,
   input logic mmio_rd_valid
);

   // raised by any failing assertion so the testbench can end the run
   logic violated = 1'b0;

   // a push into a full write channel would be dropped by the host
   push_legal: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
   else begin
      violated = 1'b1;
      $error("wr_en asserted while full is high");
   end

   // a pop is only legal while a line is presented and the transfer is not complete
   pop_legal: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty && !rd_done)
   else begin
      violated = 1'b1;
      $error("rd_en asserted while empty is high or after rd_done");
   end

   // both channel starts are single-cycle pulses
   go_pulse: assert property (@(posedge clk) disable iff (rst)
      (rd_go |=> !rd_go) and (wr_go |=> !wr_go))
   else begin
      violated = 1'b1;
      $error("rd_go or wr_go held high for more than one cycle");
   end

   // every read strobe gets exactly one response on the next cycle
   rd_latency: assert property (@(posedge clk) disable iff (rst)
      mmio_rd_valid == $past(mmio_rd_en))
   else begin
      violated = 1'b1;
      $error("mmio_rd_valid does not follow mmio_rd_en by one cycle");
   end

endmodule

bind miner_afu miner_afu_checker u_checker (.*);

// ==== testbench/miner_afu_tb.sv ====
// testbench for the miner accelerator with MMIO driver, host DMA model and result scoreboard
`timescale 1ns/100ps

module miner_afu_tb;
   import miner_pkg::*;

   logic clk = 1'b0;
   logic rst;
   logic mmio_wr_en, mmio_rd_en, mmio_rd_valid;
   logic [MMIO_ADDR_WIDTH-1:0] mmio_wr_addr, mmio_rd_addr;
   logic [63:0] mmio_wr_data, mmio_rd_data;
   logic rd_go, rd_en, empty, rd_done, wr_go, wr_en, full, wr_done;
   logic [ADDR_WIDTH-1:0] rd_addr, wr_addr;
   logic [SIZE_WIDTH-1:0] rd_size, wr_size;
   line_t rd_data, wr_data;

   // host memory holds headers and captured results, indexed by byte address
   logic [63:0] host_mem [logic [63:0]];
   logic [63:0] rd_ptr = '0;
   logic [63:0] wr_ptr = '0;
   logic [63:0] exp_rd_base, exp_wr_base;
   // job count programmed for the running job, expected on both DMA size ports
   int exp_size = 0;
   int rd_left = 0;
   int wr_left = 0;
   logic rd_started = 1'b0;
   logic wr_started = 1'b0;
   logic [15:0] lfsr = 16'd78;

   miner_afu UUT (.*);

   always #5 clk = ~clk;

   // ========================================
   // helpers
   // ========================================

   // galois LFSR stepped once for every random bit handed out
   function automatic logic next_bit();
      next_bit = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
   endfunction

   // reference hash where each xor-shift folds the upper half into the low half
   function automatic logic [31:0] ref_hash(input logic [31:0] seed, input int n);
      logic [31:0] v;
      logic [63:0] wide;
      v = seed ^ n[31:0];
      v[15:0] = v[15:0] ^ v[31:16];
      wide = {32'd0, v} * 64'h045D9F3B;
      v = wide[31:0];
      v[15:0] = v[15:0] ^ v[31:16];
      return v;
   endfunction

   // result line as found, nonce, hash for the first nonce under the target
   function automatic logic [63:0] expected_result(input logic [31:0] seed,
                                                   input logic [31:0] target);
      logic [31:0] h;
      for (int n = 0; n <= NONCE_LIMIT; n++) begin
         h = ref_hash(seed, n);
         if (h < target)
            return {1'b1, 31'(n), h};
      end
      return {1'b0, 31'(NONCE_LIMIT), ref_hash(seed, NONCE_LIMIT)};
   endfunction

   task automatic stop_on_failure(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp)
      else stop_on_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
   endtask

   task automatic mmio_write(input logic [MMIO_ADDR_WIDTH-1:0] addr, input logic [63:0] data);
      mmio_wr_en = 1'b1;
      mmio_wr_addr = addr;
      mmio_wr_data = data;
      @(posedge clk);
      #1;
      mmio_wr_en = 1'b0;
   endtask

   task automatic mmio_read(input logic [MMIO_ADDR_WIDTH-1:0] addr, output logic [63:0] data);
      int waited;
      waited = 0;
      mmio_rd_en = 1'b1;
      mmio_rd_addr = addr;
      @(posedge clk);
      #1;
      mmio_rd_en = 1'b0;
      while (!mmio_rd_valid) begin
         if (waited == 4)
            stop_on_failure("no MMIO read response after the read strobe");
         @(posedge clk);
         #1;
         waited++;
      end
      data = mmio_rd_data;
   endtask

   // loads count headers, starts the job, polls done and scores every result line
   task automatic run_job(input string name, input int count, input logic [31:0] seed0,
                          input logic [31:0] target, input logic [63:0] rd_b,
                          input logic [63:0] wr_b);
      logic [63:0] v;
      int polls;
      for (int k = 0; k < count; k++)
         host_mem[rd_b + 64'(8 * k)] = {target, seed0 + 32'(k)};
      exp_rd_base = rd_b;
      exp_wr_base = wr_b;
      exp_size = count;
      mmio_write(REG_RD_BASE, rd_b);
      mmio_write(REG_WR_BASE, wr_b);
      mmio_write(REG_SIZE, 64'(count));
      mmio_write(REG_GO, 64'd0);
      // done drops on the go pulse one cycle after the write
      @(posedge clk);
      #1;
      mmio_read(REG_DONE, v);
      check_value({name, " done cleared"}, 64'd0, v);
      polls = 0;
      while (v != 64'd1) begin
         if (polls == 20000)
            stop_on_failure({"timeout waiting for REG_DONE in ", name});
         mmio_read(REG_DONE, v);
         polls++;
      end
      for (int k = 0; k < count; k++) begin
         if (!host_mem.exists(wr_b + 64'(8 * k)))
            stop_on_failure($sformatf("%s wrote no result line for job %0d", name, k));
         check_value(name, expected_result(seed0 + 32'(k), target), host_mem[wr_b + 64'(8 * k)]);
      end
   endtask

   // ========================================
   // host DMA model
   // ========================================

   // DUT strobes are sampled at the falling edge where they are settled
   always @(negedge clk) begin
      if (UUT.u_checker.violated)
         stop_on_failure("a bound DMA or MMIO protocol assertion failed");
      if (rst) begin
         rd_left = 0;
         wr_left = 0;
         rd_started = 1'b0;
         wr_started = 1'b0;
      end else begin
         if (rd_go) begin
            check_value("read base", exp_rd_base, rd_addr);
            check_value("read size", 64'(exp_size), 64'(rd_size));
            rd_ptr = rd_addr;
            rd_left = rd_size;
            rd_started = 1'b1;
         end
         if (rd_en) begin
            rd_ptr = rd_ptr + 64'd8;
            rd_left--;
         end
         if (wr_go) begin
            check_value("write base", exp_wr_base, wr_addr);
            check_value("write size", 64'(exp_size), 64'(wr_size));
            wr_ptr = wr_addr;
            wr_left = wr_size;
            wr_started = 1'b1;
         end
         if (wr_en) begin
            host_mem[wr_ptr] = wr_data;
            wr_ptr = wr_ptr + 64'd8;
            wr_left--;
         end
      end
   end

   // channel levels are driven just after the rising edge, with random stalls on both
   always @(posedge clk) begin
      logic stall_rd;
      logic stall_wr;
      #1;
      stall_rd = next_bit();
      stall_wr = next_bit();
      empty = rst || (rd_left == 0) || stall_rd;
      full = rst || !wr_started || (wr_left == 0) || stall_wr;
      rd_data = host_mem.exists(rd_ptr) ? host_mem[rd_ptr] : '0;
      rd_done = rd_started && (rd_left == 0);
      wr_done = wr_started && (wr_left == 0);
   end

   // ========================================
   // test sequence
   // ========================================

   initial begin
      logic [63:0] v;
      rst = 1'b1;
      mmio_wr_en = 1'b0;
      mmio_wr_addr = '0;
      mmio_wr_data = '0;
      mmio_rd_en = 1'b0;
      mmio_rd_addr = '0;
      empty = 1'b1;
      full = 1'b1;
      rd_data = '0;
      rd_done = 1'b0;
      wr_done = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      mmio_read(REG_DONE, v);
      check_value("done after reset", 64'd0, v);
      mmio_write(REG_RD_BASE, 64'h0000_0001_2345_6780);
      mmio_read(REG_RD_BASE, v);
      check_value("read base readback", 64'h0000_0001_2345_6780, v);
      mmio_write(REG_WR_BASE, 64'h0000_0002_0000_0100);
      mmio_read(REG_WR_BASE, v);
      check_value("write base readback", 64'h0000_0002_0000_0100, v);
      mmio_write(REG_SIZE, 64'h00A5);
      mmio_read(REG_SIZE, v);
      check_value("size readback", 64'h00A5, v);

      run_job("found nonce", 1, 32'hCAFE_0001, 32'h1000_0000, 64'h1000, 64'h8000);
      run_job("search exhausted", 1, 32'h0BAD_5EED, 32'h0, 64'h2000, 64'h9000);
      run_job("multi job", 5, 32'h1234_0000, 32'h0800_0000, 64'h3000, 64'hA000);

      if (UUT.u_checker.violated) begin
         stop_on_failure("a bound DMA or MMIO protocol assertion failed");
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule
